/* list.f */
source/sm83_pkg.sv
source/sm83_alu.sv
source/sm83_alu_sequencer.sv
source/sm83_acc_flag_regs.sv
source/sm83_alu_unit.sv
tb/sm83_alu_unit_tb.sv

/* source/sm83_acc_flag_regs.sv */
// Accumulator and flag register

`timescale 1ns/1ns
`default_nettype none

module sm83_acc_flag_regs
	import sm83_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   acc_load, // Direct write of acc_value
	input  byte_t  acc_value,
	input  logic   commit, // Sequencer result valid
	input  logic   acc_write, // Qualifies commit for acc
	input  byte_t  result, // ALU bus
	input  flags_t new_flags,
	output byte_t  acc,
	output flags_t flags
);

	// Acc, a direct load wins over a commit in the same cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			acc <= '0;
		end else if (acc_load) begin
			acc <= acc_value;
		end else if (commit && acc_write) begin
			acc <= result;
		end
	end

	// Flags, written by every operation including CP
	always_ff @(posedge clk) begin
		if (reset) begin
			flags <= '0;
		end else if (commit) begin
			flags <= new_flags;
		end
	end

endmodule

`default_nettype wire

/* source/sm83_alu.sv */
// Nibble-serial ALU core

`timescale 1ns/1ns
`default_nettype none

module sm83_alu
	import sm83_pkg::*;
(
	input  logic      clk,
	input  byte_t     din, // Data in, onto the bus with din_oe
	input  alu_ctrl_t ctrl,
	output byte_t     dout, // ALU bus
	output logic      carry, // Carry out of the last slice
	output logic      zero // Bus is all zero
);

	// ##################################################################
	// Slice logic
	// ##################################################################

	// One bit of the R/S/V carry chain, returns {result, carry out}
	function automatic logic [1:0] alu_slice(
		input logic a,
		input logic b,
		input logic c_in,
		input logic r_sig,
		input logic s_sig,
		input logic v_sig
	);
		logic nc;
		logic r;
		logic c_out;
		nc = !(((a | b) & c_in) | (a & b) | s_sig); // Low when a carry is generated or forced
		r = (a & b & c_in) | ((a | b | c_in) & (v_sig | nc));
		c_out = !(r_sig | nc); // R kills the carry for OR and XOR
		return {r, c_out};
	endfunction

	byte_t op_a; // Operand A register
	byte_t op_b; // Operand B register
	nibble_t core_a; // Half of A fed into the chain
	nibble_t core_b; // Half of B, maybe inverted
	nibble_t core_result;
	nibble_t res_lo; // Low result from the op_low step
	byte_t result;
	byte_t bus;

	// Half selects
	always_comb begin
		core_a = ctrl.op_low ? op_a[nibble_width-1:0] : op_a[byte_width-1:nibble_width];
		core_b = ctrl.op_b_high ? op_b[byte_width-1:nibble_width] : op_b[nibble_width-1:0];
		if (ctrl.negate) begin
			core_b = ~core_b; // Subtract as A + ~B + carry
		end
	end

	// Ripple through four slices
	always_comb begin : chain
		logic c;
		logic [1:0] slice_out;
		c = ctrl.carry_in;
		for (int i = 0; i < nibble_width; i++) begin
			slice_out = alu_slice(core_a[i], core_b[i], c, ctrl.no_carry_out,
				ctrl.force_carry, ctrl.ignore_carry);
			core_result[i] = slice_out[1];
			c = slice_out[0];
		end
		carry = c;
	end

	// ##################################################################
	// Registers and bus
	// ##################################################################

	// Operands load on the falling edge, mid-cycle of the load step
	always_ff @(negedge clk) begin
		if (ctrl.load_a) begin
			op_a <= bus;
		end else if (ctrl.load_a_zero) begin
			op_a <= '0;
		end
	end

	always_ff @(negedge clk) begin
		if (ctrl.load_b) begin
			op_b <= bus;
		end else if (ctrl.load_b_zero) begin
			op_b <= '0;
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl.op_low) begin
			res_lo <= core_result; // Held for the high step
		end
	end

	assign result = {core_result, res_lo};

	// One source drives the bus at a time
	always_comb begin
		if (ctrl.result_oe) begin
			bus = result;
		end else if (ctrl.din_oe) begin
			bus = din;
		end else if (ctrl.op_a_oe) begin
			bus = op_a;
		end else begin
			bus = '0; // Idle bus
		end
	end

	assign dout = bus;
	assign zero = (bus == '0);

endmodule

`default_nettype wire

/* source/sm83_alu_sequencer.sv */
// ALU operation sequencer

`timescale 1ns/1ns
`default_nettype none

module sm83_alu_sequencer
	import sm83_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      start, // Pulse, ignored while busy
	input  alu_op_t   op,
	input  byte_t     operand,
	input  byte_t     acc, // Source for operand A
	input  logic      flag_c, // Carry flag for ADC and SBC
	input  logic      alu_carry,
	input  logic      alu_zero,
	output byte_t     alu_din,
	output alu_ctrl_t alu_ctrl,
	output logic      commit, // Result valid, write at next edge
	output logic      acc_write, // Acc takes result, low for CP
	output flags_t    new_flags,
	output logic      done
);

	seq_state_t state;
	alu_op_t op_q; // Captured op
	byte_t operand_q; // Captured operand
	logic low_carry; // Carry out of the low nibble

	logic is_sub;
	logic is_logic;
	logic low_cin; // Carry into the low step
	logic r_sig;
	logic s_sig;
	logic v_sig;

	// ##################################################################
	// FSM
	// ##################################################################

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			done <= 1'b0;
			low_carry <= 1'b0;
		end else begin
			done <= (state == st_high); // Acc and flags written at the same edge
			if (state == st_low) begin
				low_carry <= alu_carry;
			end
			case (state)
				st_idle: if (start) state <= st_load_a;
				st_load_a: state <= st_load_b;
				st_load_b: state <= st_low;
				st_low: state <= st_high;
				st_high: state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && start) begin
			op_q <= op;
			operand_q <= operand;
		end
	end

	// ##################################################################
	// Per-op chain pattern
	// ##################################################################

	assign is_sub = (op_q == op_sub) || (op_q == op_sbc) || (op_q == op_cp);
	assign is_logic = (op_q == op_and) || (op_q == op_xor) || (op_q == op_or);

	always_comb begin
		r_sig = 1'b0;
		s_sig = 1'b0;
		v_sig = 1'b0;
		low_cin = 1'b0;
		case (op_q)
			op_adc: low_cin = flag_c;
			op_sub, op_cp: low_cin = 1'b1; // A + ~B + 1
			op_sbc: low_cin = !flag_c; // Borrow in
			op_and: begin
				s_sig = 1'b1; // Forced carry gates each bit as a AND b
				low_cin = 1'b1;
			end
			op_xor: r_sig = 1'b1;
			op_or: begin
				r_sig = 1'b1;
				v_sig = 1'b1;
			end
			default: low_cin = 1'b0; // ADD
		endcase
	end

	always_comb begin
		alu_ctrl = '0;
		case (state)
			st_load_a: begin
				alu_ctrl.din_oe = 1'b1;
				alu_ctrl.load_a = 1'b1;
			end
			st_load_b: begin
				alu_ctrl.din_oe = 1'b1;
				alu_ctrl.load_b = 1'b1;
			end
			st_low: begin
				alu_ctrl.op_low = 1'b1; // Low halves, latch low result
				alu_ctrl.carry_in = low_cin;
				alu_ctrl.no_carry_out = r_sig;
				alu_ctrl.force_carry = s_sig;
				alu_ctrl.ignore_carry = v_sig;
				alu_ctrl.negate = is_sub;
			end
			st_high: begin
				alu_ctrl.op_b_high = 1'b1;
				alu_ctrl.carry_in = low_carry; // Chain continues from the low nibble
				alu_ctrl.no_carry_out = r_sig;
				alu_ctrl.force_carry = s_sig;
				alu_ctrl.ignore_carry = v_sig;
				alu_ctrl.negate = is_sub;
				alu_ctrl.result_oe = 1'b1;
			end
			default: alu_ctrl = '0;
		endcase
	end

	assign alu_din = (state == st_load_b) ? operand_q : acc;

	// Flags from the high step, the chain carry is inverted into a borrow for subtracts
	assign commit = (state == st_high);
	assign acc_write = (op_q != op_cp);
	assign new_flags.z = alu_zero;
	assign new_flags.n = is_sub;
	assign new_flags.h = (op_q == op_and) ? 1'b1 :
		is_logic ? 1'b0 : (low_carry ^ is_sub);
	assign new_flags.c = is_logic ? 1'b0 : (alu_carry ^ is_sub);

endmodule

`default_nettype wire

/* source/sm83_alu_unit.sv */
// SM83 ALU subsystem top

`timescale 1ns/1ns
`default_nettype none

module sm83_alu_unit
	import sm83_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    start,
	input  alu_op_t op,
	input  byte_t   operand,
	input  logic    acc_load,
	input  byte_t   acc_value,
	output byte_t   acc,
	output flags_t  flags,
	output logic    done
);

	alu_ctrl_t alu_ctrl;
	byte_t alu_din;
	byte_t alu_dout; // ALU bus, carries the result in st_high
	logic alu_carry;
	logic alu_zero;
	logic commit;
	logic acc_write;
	flags_t new_flags;

	sm83_alu_sequencer seq_i (
		.clk(clk),
		.reset(reset),
		.start(start),
		.op(op),
		.operand(operand),
		.acc(acc),
		.flag_c(flags.c),
		.alu_carry(alu_carry),
		.alu_zero(alu_zero),
		.alu_din(alu_din),
		.alu_ctrl(alu_ctrl),
		.commit(commit),
		.acc_write(acc_write),
		.new_flags(new_flags),
		.done(done)
	);

	sm83_alu alu_i (
		.clk(clk),
		.din(alu_din),
		.ctrl(alu_ctrl),
		.dout(alu_dout),
		.carry(alu_carry),
		.zero(alu_zero)
	);

	sm83_acc_flag_regs regs_i (
		.clk(clk),
		.reset(reset),
		.acc_load(acc_load),
		.acc_value(acc_value),
		.commit(commit),
		.acc_write(acc_write),
		.result(alu_dout),
		.new_flags(new_flags),
		.acc(acc),
		.flags(flags)
	);

endmodule

`default_nettype wire

/* source/sm83_pkg.sv */
// SM83 ALU shared definitions

`default_nettype none

package sm83_pkg;

	// ##################################################################
	// Widths
	// ##################################################################

	localparam int nibble_width = 4; // One ALU slice chain
	localparam int byte_width = 8; // Accumulator and bus word

	typedef logic [nibble_width-1:0] nibble_t; // Half operand or half result
	typedef logic [byte_width-1:0] byte_t; // Full data word

	// ##################################################################
	// Encodings
	// ##################################################################

	// Accumulator ops in SM83 opcode order (bits 5:3 of the ALU opcodes)
	typedef enum logic [2:0] {
		op_add = 3'd0,
		op_adc = 3'd1,
		op_sub = 3'd2,
		op_sbc = 3'd3,
		op_and = 3'd4,
		op_xor = 3'd5,
		op_or  = 3'd6,
		op_cp  = 3'd7
	} alu_op_t;

	typedef enum logic [2:0] {
		st_idle,
		st_load_a, // Acc onto bus, into operand A
		st_load_b, // Operand onto bus, into operand B
		st_low, // Low nibble through the chain
		st_high // High nibble, full result on bus
	} seq_state_t;

	// Control strobes from the sequencer into the ALU core
	typedef struct packed {
		logic din_oe; // Pass din to the bus
		logic result_oe; // Core result to the bus
		logic op_a_oe; // Operand A to the bus
		logic load_a; // Load bus into A on falling edge
		logic load_a_zero; // Clear A on falling edge
		logic load_b; // Load bus into B on falling edge
		logic load_b_zero; // Clear B on falling edge
		logic carry_in; // Carry into slice 0
		logic no_carry_out; // R
		logic force_carry; // S
		logic ignore_carry; // V
		logic negate; // Invert operand B into the chain
		logic op_low; // 1 selects low half of A, latches low result
		logic op_b_high; // 1 selects high half of B
	} alu_ctrl_t;

	typedef struct packed {
		logic z;
		logic n;
		logic h;
		logic c;
	} flags_t;

endpackage

`default_nettype wire

/* tb/sm83_alu_unit_tb.sv */
// SM83 ALU subsystem testbench

`timescale 1ns/1ns
`default_nettype none

module sm83_alu_unit_tb
	import sm83_pkg::*;
;

	// ####################################################################
	// Setup
	// ####################################################################

	localparam int directed_ops = 29; // Issued by the directed groups
	localparam int random_ops = 300;
	localparam int timeout_cycles = (directed_ops + random_ops) * 6 + 100;
	localparam int done_latency = 4; // Rising edges from start to done

	logic clk;
	logic reset;
	logic start;
	alu_op_t op;
	byte_t operand;
	logic acc_load;
	byte_t acc_value;
	byte_t acc;
	flags_t flags;
	logic done;

	byte_t model_acc; // Model state, updated when an op is issued
	flags_t model_flags;
	byte_t exp_acc[$]; // Expected results in issue order
	flags_t exp_flags[$];
	int exp_edge[$]; // Edge that samples start
	int cycle = 0;
	int errors = 0;
	int checked = 0;
	int test_err_start;
	int test_chk_start;

	sm83_alu_unit dut_i (
		.clk(clk),
		.reset(reset),
		.start(start),
		.op(op),
		.operand(operand),
		.acc_load(acc_load),
		.acc_value(acc_value),
		.acc(acc),
		.flags(flags),
		.done(done)
	);

	always #5 clk = ~clk;

	// Cycle count and run limit
	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= timeout_cycles) begin
			$display("Run stopped after %0d cycles, done never arrived", cycle);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// ####################################################################
	// Reference model
	// ####################################################################

	// Returns {new acc, new flags}
	function automatic logic [11:0] ref_alu(input alu_op_t o, input byte_t a,
		input byte_t b, input logic c_old);
		int sum;
		int lo;
		int cin;
		byte_t res;
		byte_t new_acc;
		flags_t f;
		f = '0;
		cin = 0;
		case (o)
			op_add, op_adc: begin
				cin = (o == op_adc) ? int'(c_old) : 0;
				sum = int'(a) + int'(b) + cin;
				lo = int'(a[3:0]) + int'(b[3:0]) + cin;
				res = sum[7:0];
				f.h = (lo > 15); // Carry out of bit 3
				f.c = (sum > 255);
			end
			op_sub, op_sbc, op_cp: begin
				cin = (o == op_sbc) ? int'(c_old) : 0;
				sum = int'(a) - int'(b) - cin;
				lo = int'(a[3:0]) - int'(b[3:0]) - cin;
				res = sum[7:0];
				f.n = 1'b1;
				f.h = (lo < 0); // Borrow from bit 4
				f.c = (sum < 0);
			end
			op_and: begin
				res = a & b;
				f.h = 1'b1;
			end
			op_xor: res = a ^ b;
			default: res = a | b; // OR
		endcase
		f.z = (res == 8'h00);
		new_acc = (o == op_cp) ? a : res; // CP only compares
		return {new_acc, f};
	endfunction

	// Compare at each done, sampled on the falling edge
	always @(negedge clk) begin : check_done
		byte_t want_acc;
		flags_t want_flags;
		int start_edge;
		if (!reset && done) begin
			if (exp_acc.size() == 0) begin
				$display("Unexpected done with no operation outstanding, cycle %0d", cycle);
				errors++;
			end else begin
				want_acc = exp_acc.pop_front();
				want_flags = exp_flags.pop_front();
				start_edge = exp_edge.pop_front();
				if (cycle - start_edge != done_latency) begin
					$display("done came %0d cycles after start, expected %0d",
						cycle - start_edge, done_latency);
					errors++;
				end
				if (acc !== want_acc) begin
					$display("[ERROR] acc: got 0x%h expected 0x%h", acc, want_acc);
					errors++;
				end
				if (flags !== want_flags) begin
					$display("[ERROR] flags: got 0x%h expected 0x%h", flags, want_flags);
					errors++;
				end
				checked++;
			end
		end
	end

	// ####################################################################
	// Stimulus tasks, all entered just after a falling edge
	// ####################################################################

	task automatic issue_op(input alu_op_t o, input byte_t b);
		logic [11:0] r;
		start = 1'b1;
		op = o;
		operand = b;
		r = ref_alu(o, model_acc, b, model_flags.c);
		model_acc = r[11:4];
		model_flags = r[3:0];
		exp_acc.push_back(model_acc);
		exp_flags.push_back(model_flags);
		exp_edge.push_back(cycle + 1); // Next rising edge samples start
		@(negedge clk);
		start = 1'b0;
	endtask

	task automatic wait_done();
		do
			@(negedge clk);
		while (!done);
	endtask

	task automatic run_op(input alu_op_t o, input byte_t b);
		issue_op(o, b);
		wait_done();
		@(negedge clk);
	endtask

	task automatic load_acc(input byte_t v);
		acc_load = 1'b1;
		acc_value = v;
		model_acc = v;
		@(negedge clk);
		acc_load = 1'b0;
	endtask

	task automatic begin_test();
		test_err_start = errors;
		test_chk_start = checked;
	endtask

	task automatic report_test(input string name);
		$display("%-10s finished, %0d ops checked, %0d errors", name,
			checked - test_chk_start, errors - test_err_start);
	endtask

	// ####################################################################
	// Test sequence
	// ####################################################################

	initial begin : main
		logic [2:0] rnd_op;
		clk = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		op = op_add;
		operand = '0;
		acc_load = 1'b0;
		acc_value = '0;
		model_acc = '0;
		model_flags = '0;
		void'($urandom(32'h613eea0a));
		repeat (5) @(negedge clk);
		reset = 1'b0;
		if (acc !== 8'h00 || flags !== 4'h0) begin
			$display("acc and flags are not zero after reset");
			errors++;
		end

		begin_test(); // Half carry, full carry, chained ADC
		load_acc(8'h0f);
		run_op(op_add, 8'h01);
		run_op(op_add, 8'hf0);
		run_op(op_adc, 8'h05);
		load_acc(8'h8f);
		run_op(op_add, 8'h91);
		run_op(op_adc, 8'h00);
		run_op(op_add, 8'h3a);
		report_test("add_adc");

		begin_test(); // Borrows, SBC chaining, CP keeps acc
		load_acc(8'h10);
		run_op(op_sub, 8'h01);
		run_op(op_sub, 8'h20);
		run_op(op_sbc, 8'h0e);
		run_op(op_sub, 8'hf0);
		run_op(op_sbc, 8'h10);
		run_op(op_cp, 8'hdf);
		run_op(op_cp, 8'he0);
		report_test("sub_cp");

		begin_test();
		load_acc(8'hf0);
		run_op(op_and, 8'h3c);
		run_op(op_and, 8'h0f);
		load_acc(8'h5a);
		run_op(op_or, 8'h0f);
		run_op(op_or, 8'ha0);
		run_op(op_xor, 8'h0f);
		run_op(op_xor, 8'haa);
		run_op(op_and, 8'hff);
		report_test("logic");

		begin_test(); // Zero results and a few non-zero ones
		load_acc(8'h42);
		run_op(op_sub, 8'h42);
		load_acc(8'h77);
		run_op(op_xor, 8'h77);
		load_acc(8'hff);
		run_op(op_add, 8'h01);
		run_op(op_add, 8'h01);
		run_op(op_or, 8'h00);
		report_test("zero");

		begin_test();
		issue_op(op_add, 8'h11);
		wait_done();
		issue_op(op_sub, 8'h01); // Start in the done cycle
		wait_done();
		@(negedge clk);
		issue_op(op_adc, 8'h22);
		start = 1'b1; // Busy cycles, these starts are dropped
		op = op_xor;
		operand = 8'hff;
		repeat (2) @(negedge clk);
		start = 1'b0;
		wait_done();
		repeat (6) @(negedge clk); // A second done here is flagged
		run_op(op_cp, 8'h00);
		report_test("timing");

		begin_test();
		for (int i = 0; i < random_ops; i++) begin
			if ($urandom % 8 == 0) begin
				load_acc(byte_t'($urandom));
			end
			rnd_op = $urandom;
			run_op(alu_op_t'(rnd_op), byte_t'($urandom));
		end
		report_test("random");

		repeat (3) @(negedge clk);
		if (exp_acc.size() != 0) begin
			$display("%0d operations never signalled done", exp_acc.size());
			errors++;
		end
		$display("Checked %0d operations, %0d errors", checked, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
